// File: verilog.f
+incdir+sim
design/decode_pkg.sv
design/main_decoder.sv
design/flow_decoder.sv
design/exec_decoder.sv
design/mem_decoder.sv
design/muldiv_decoder.sv
design/decode_reg.sv
design/instr_decode.sv
sim/tb_instr_decode.sv

// File: Bender.yml
package:
  name: instr_decode

sources:
  - design/decode_pkg.sv
  - design/main_decoder.sv
  - design/flow_decoder.sv
  - design/exec_decoder.sv
  - design/mem_decoder.sv
  - design/muldiv_decoder.sv
  - design/decode_reg.sv
  - design/instr_decode.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_instr_decode.sv

// File: sim/decode_ref.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Expected control record, built from the instruction groups field by field
function automatic ctrl_t decode_ref(input logic [INSTR_W-1:0] word);
    logic [OP_W-1:0]    op;
    logic [REG_W-1:0]   rt;
    logic [FUNCT_W-1:0] fn;
    logic               sp;
    logic               sp2;
    logic               ri;
    logic               ld;
    logic               st;
    logic               alu_r;
    logic               sft_r;
    logic               known;
    ctrl_t              c;

    op    = word[31:26];
    rt    = word[20:16];
    fn    = word[5:0];
    sp    = op == OP_SPECIAL;
    sp2   = op == OP_SPECIAL2;
    ri    = op == OP_REGIMM;
    ld    = op inside {OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR};
    st    = op inside {OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR};
    alu_r = sp && fn inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                             FN_AND, FN_OR, FN_XOR, FN_NOR};
    sft_r = sp && fn inside {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
    known = alu_r || sft_r || ld || st
            || (sp && fn inside {FN_JR, FN_JALR, FN_SYSCALL, FN_BREAK, FN_SYNC, FN_MFHI,
                                 FN_MTHI, FN_MFLO, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU})
            || (sp2 && fn inside {FN2_MADD, FN2_MADDU, FN2_MUL, FN2_MSUB, FN2_MSUBU})
            || (ri && rt inside {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL})
            || op inside {OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_ADDI, OP_ADDIU,
                          OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    c = '0;  // All-zero record is the idle default

    c.main.reserved = !known;
    c.main.brk      = sp && fn == FN_BREAK;
    c.main.syscall  = sp && fn == FN_SYSCALL;
    c.main.regwrite = alu_r || sft_r || ld || (sp && fn inside {FN_JALR, FN_MFHI, FN_MFLO})
                      || (sp2 && fn == FN2_MUL) || (ri && !(rt inside {RI_BLTZ, RI_BGEZ}))
                      || op inside {OP_JAL, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
                                    OP_ORI, OP_XORI, OP_LUI};
    if (c.main.regwrite)
    begin
        if (sp || sp2)
            c.main.regdst = DST_RD;
        else if (ri || op == OP_JAL)
            c.main.regdst = DST_R31;  // Link register
    end
    if (sft_r || op == OP_LUI)
        c.main.out_sel = OUT_SHIFT;
    else if (sp && fn == FN_MFHI)
        c.main.out_sel = OUT_HI;
    else if (sp && fn == FN_MFLO)
        c.main.out_sel = OUT_LO;
    else if (sp2 && fn == FN2_MUL)
        c.main.out_sel = OUT_MUL;

    c.flow.isbranch = ri || op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ};
    c.flow.isjump   = op inside {OP_J, OP_JAL} || (sp && fn inside {FN_JR, FN_JALR});
    c.flow.link     = op == OP_JAL || (sp && fn == FN_JALR)
                      || (ri && rt inside {RI_BLTZAL, RI_BGEZAL});
    case (op)
        OP_BNE:  c.flow.branch = BR_BNE;
        OP_BLEZ: c.flow.branch = BR_BLEZ;
        OP_BGTZ: c.flow.branch = BR_BGTZ;
        OP_JAL:  c.flow.jump = JMP_JAL;
        default: ;
    endcase
    if (ri)
    begin
        case (rt)
            RI_BLTZ:   c.flow.branch = BR_BLTZ;
            RI_BGEZ:   c.flow.branch = BR_BGEZ;
            RI_BLTZAL: c.flow.branch = BR_BLTZAL;
            RI_BGEZAL: c.flow.branch = BR_BGEZAL;
            default: ;
        endcase
    end
    if (sp && fn == FN_JR)
        c.flow.jump = JMP_JR;
    if (sp && fn == FN_JALR)
        c.flow.jump = JMP_JALR;

    c.exec.sft_srca_sel_imm = op == OP_LUI;
    c.exec.imm_sign         = ld || st || op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
    c.exec.intovf_en        = op == OP_ADDI || (sp && fn inside {FN_ADD, FN_SUB});
    c.exec.sft_srcb_sel_rs  = sp && fn inside {FN_SLLV, FN_SRLV, FN_SRAV};
    c.exec.alu_srcb_sel_rt  = alu_r || (sp && fn inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU})
                              || (sp2 && fn inside {FN2_MADD, FN2_MADDU, FN2_MSUB, FN2_MSUBU});
    if (sp)
    begin
        case (fn)
            FN_SUB, FN_SUBU: c.exec.alu_func = ALU_SUB;
            FN_SLT:          c.exec.alu_func = ALU_SLT;
            FN_SLTU:         c.exec.alu_func = ALU_SLTU;
            FN_AND:          c.exec.alu_func = ALU_AND;
            FN_NOR:          c.exec.alu_func = ALU_NOR;
            FN_OR:           c.exec.alu_func = ALU_OR;
            FN_XOR:          c.exec.alu_func = ALU_XOR;
            FN_SLL, FN_SLLV: c.exec.sft_func = SFT_SLL;
            FN_SRA, FN_SRAV: c.exec.sft_func = SFT_SRA;
            FN_SRL, FN_SRLV: c.exec.sft_func = SFT_SRL;
            default: ;
        endcase
    end
    else
    begin
        case (op)
            OP_SLTI:  c.exec.alu_func = ALU_SLT;
            OP_SLTIU: c.exec.alu_func = ALU_SLTU;
            OP_ANDI:  c.exec.alu_func = ALU_AND;
            OP_ORI:   c.exec.alu_func = ALU_OR;
            OP_XORI:  c.exec.alu_func = ALU_XOR;
            default: ;
        endcase
    end

    c.mem.memreq     = ld || st;
    c.mem.memwr      = st;
    c.mem.memtoreg   = ld;
    c.mem.rdata_sign = op inside {OP_LB, OP_LH, OP_LW};
    if (op inside {OP_LH, OP_LHU, OP_SH})
        c.mem.size = SIZE_HALF;
    else if (op inside {OP_LW, OP_SW, OP_LWL, OP_LWR, OP_SWL, OP_SWR})
        c.mem.size = SIZE_WORD;
    case (op)
        OP_LWL:  c.mem.lwlr = LR_LEFT;
        OP_LWR:  c.mem.lwlr = LR_RIGHT;
        OP_SWL:  c.mem.swlr = LR_LEFT;
        OP_SWR:  c.mem.swlr = LR_RIGHT;
        default: ;
    endcase

    c.muldiv.mul_en   = (sp && fn inside {FN_MULT, FN_MULTU})
                        || (sp2 && fn inside {FN2_MUL, FN2_MADD, FN2_MADDU, FN2_MSUB, FN2_MSUBU});
    c.muldiv.mul_sign = (sp && fn == FN_MULT) || (sp2 && fn inside {FN2_MUL, FN2_MADD, FN2_MSUB});
    c.muldiv.div_en   = sp && fn inside {FN_DIV, FN_DIVU};
    c.muldiv.div_sign = sp && fn == FN_DIV;
    if (sp2 && fn inside {FN2_MADD, FN2_MADDU})
        c.muldiv.mul_mode = MUL_ACC;
    else if (sp2 && fn inside {FN2_MSUB, FN2_MSUBU})
        c.muldiv.mul_mode = MUL_SUB;
    if (c.muldiv.div_en)
    begin
        c.muldiv.hi_sel = HILO_DIV;
        c.muldiv.lo_sel = HILO_DIV;
    end
    if (sp && fn == FN_MTHI)
        c.muldiv.hi_sel = HILO_RS;
    if (sp && fn == FN_MTLO)
        c.muldiv.lo_sel = HILO_RS;
    // MUL writes a GPR only, every other multiply goes to HI/LO
    c.muldiv.hi_wen = (c.muldiv.mul_en && !(sp2 && fn == FN2_MUL)) || c.muldiv.div_en
                      || (sp && fn == FN_MTHI);
    c.muldiv.lo_wen = (c.muldiv.mul_en && !(sp2 && fn == FN2_MUL)) || c.muldiv.div_en
                      || (sp && fn == FN_MTLO);
    return c;
endfunction

`endif

// File: sim/tb_instr_decode.sv
`timescale 1ns/100ps

module tb_instr_decode import decode_pkg::*; ();

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    instr_t   in_data;
    logic     out_ready;
    logic     flush;
    logic     in_ready;
    logic     out_valid;
    decoded_t out_data;

    integer   seed;
    logic     random_flow;  // Random out_ready and flush when set
    logic     timed_out;
    int       check_errors;
    int       timeouts;
    int       transfers;
    int       killed;
    instr_t   exp_q[$];     // Accepted, not yet out
    instr_t   front;
    logic     stalled;
    decoded_t held;

    `include "decode_ref.svh"

    instr_decode i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_ready (out_ready),
        .flush     (flush),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("CHECK FAILED at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
        check_errors++;
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        if (act !== exp)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
        if (act.main !== exp.main)
            report_mismatch({name, ".main"}, exp.main, act.main);
        if (act.flow !== exp.flow)
            report_mismatch({name, ".flow"}, exp.flow, act.flow);
        if (act.exec !== exp.exec)
            report_mismatch({name, ".exec"}, exp.exec, act.exec);
        if (act.mem !== exp.mem)
            report_mismatch({name, ".mem"}, exp.mem, act.mem);
        if (act.muldiv !== exp.muldiv)
            report_mismatch({name, ".muldiv"}, exp.muldiv, act.muldiv);
    endtask

    function automatic instr_t random_word();
        return instr_t'($random(seed));
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        if (random_flow)
        begin
            out_ready <= $random(seed) % 4 != 0;
            flush     <= $random(seed) % 12 == 0;
        end
    endtask

    // Holds the word until in_ready is seen at a clock edge
    task automatic send_word(input instr_t w);
        int waited;
        waited = 0;
        in_valid <= 1'b1;
        in_data  <= w;
        next_cycle();
        while (!in_ready && !timed_out)
        begin
            waited++;
            if (waited > 200)
            begin
                $display("Timeout at %0t: in_ready stayed low for 200 cycles", $time);
                timeouts++;
                timed_out = 1'b1;
            end
            else
                next_cycle();
        end
    endtask

    // Scoreboard, sampled at the edge before any update lands
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            check_flag("out_valid", exp_q.size() != 0, out_valid);
            check_flag("in_ready", exp_q.size() == 0 || out_ready, in_ready);
            if (out_valid && stalled)
            begin
                check_instr("out_data.instr while stalled", held.instr, out_data.instr);
                check_ctrl("out_data.ctrl while stalled", held.ctrl, out_data.ctrl);
            end
            if (out_valid && (out_ready || flush))
            begin
                if (exp_q.size() == 0)
                begin
                    $display("DUT offered an output at %0t with nothing accepted", $time);
                    check_errors++;
                end
                else if (out_ready)
                begin
                    front = exp_q.pop_front();
                    check_instr("out_data.instr", front, out_data.instr);
                    check_ctrl("out_data.ctrl", decode_ref(front), out_data.ctrl);
                    transfers++;
                end
                else
                begin
                    void'(exp_q.pop_front());  // Held entry killed
                    killed++;
                end
            end
            stalled = out_valid && !out_ready && !flush;
            held    = out_data;
            if (in_valid && in_ready && !flush)
                exp_q.push_back(in_data);
        end
    end

    initial
    begin
        instr_t w;
        int     waited;
        seed         = 32'h77b6_724f;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        out_ready    = 1'b0;
        flush        = 1'b0;
        random_flow  = 1'b0;
        timed_out    = 1'b0;
        check_errors = 0;
        timeouts     = 0;
        transfers    = 0;
        killed       = 0;
        stalled      = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        check_flag("out_valid after reset", 1'b0, out_valid);
        check_flag("in_ready after reset", 1'b1, in_ready);
        out_ready <= 1'b1;

        // Every SPECIAL and SPECIAL2 function, every REGIMM code, every opcode
        for (int f = 0; f < 64 && !timed_out; f++)
        begin
            w       = random_word();
            w.op    = OP_SPECIAL;
            w.funct = f[5:0];
            send_word(w);
            w.op    = OP_SPECIAL2;
            send_word(w);
        end
        for (int r = 0; r < 32 && !timed_out; r++)
        begin
            w    = random_word();
            w.op = OP_REGIMM;
            w.rt = r[4:0];
            send_word(w);
        end
        for (int o = 0; o < 64 && !timed_out; o++)
        begin
            w    = random_word();
            w.op = opcode_e'(o[5:0]);
            send_word(w);
        end

        random_flow = 1'b1;
        for (int n = 0; n < 1500 && !timed_out; n++)
        begin
            if ($random(seed) % 4 == 0)
            begin
                in_valid <= 1'b0;  // Input gap
                next_cycle();
            end
            send_word(random_word());
        end

        in_valid    <= 1'b0;
        random_flow = 1'b0;
        out_ready   <= 1'b1;
        flush       <= 1'b0;
        waited      = 0;
        next_cycle();
        while (out_valid && waited < 200)
        begin
            waited++;
            next_cycle();
        end
        if (out_valid)
        begin
            $display("Timeout at %0t: out_valid still high after 200 drain cycles", $time);
            timeouts++;
        end
        next_cycle();
        if (exp_q.size() != 0)
        begin
            $display("%0d accepted instructions never left the DUT", exp_q.size());
            check_errors++;
        end
        $display("Check failures: %0d, timeouts: %0d, compared: %0d, killed by flush: %0d",
                 check_errors, timeouts, transfers, killed);
        if (check_errors == 0 && timeouts == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: design/instr_decode.sv
`timescale 1ns/100ps

module instr_decode import decode_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  instr_t   in_data,
    input  logic     out_ready,
    input  logic     flush,
    output logic     in_ready,
    output logic     out_valid,
    output decoded_t out_data
);

    ctrl_t    ctrl;
    decoded_t decoded;

    main_decoder i_main_decoder (
        .instr (in_data),
        .ctrl  (ctrl.main)
    );

    flow_decoder i_flow_decoder (
        .instr (in_data),
        .ctrl  (ctrl.flow)
    );

    exec_decoder i_exec_decoder (
        .instr (in_data),
        .ctrl  (ctrl.exec)
    );

    mem_decoder i_mem_decoder (
        .instr (in_data),
        .ctrl  (ctrl.mem)
    );

    muldiv_decoder i_muldiv_decoder (
        .instr (in_data),
        .ctrl  (ctrl.muldiv)
    );

    assign decoded = '{instr: in_data, ctrl: ctrl};  // Word travels with its controls

    decode_reg i_decode_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (decoded),
        .out_ready (out_ready),
        .flush     (flush),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: design/decode_reg.sv
`timescale 1ns/100ps

module decode_reg import decode_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  decoded_t in_data,
    input  logic     out_ready,
    input  logic     flush,
    output logic     in_ready,
    output logic     out_valid,
    output decoded_t out_data
);

    logic load;

    assign in_ready = !out_valid || out_ready;  // Empty, or emptying this cycle
    assign load     = in_valid && in_ready && !flush;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (flush)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (load)
            out_data <= in_data;
    end

endmodule

// File: design/muldiv_decoder.sv
`timescale 1ns/100ps

module muldiv_decoder import decode_pkg::*; (
    input  instr_t       instr,
    output muldiv_ctrl_t ctrl
);

    logic is_special;
    logic is_special2;
    logic mult_op;
    logic div_op;
    logic madd_op;
    logic msub_op;
    logic mthi_op;
    logic mtlo_op;

    assign is_special  = instr.op == OP_SPECIAL;
    assign is_special2 = instr.op == OP_SPECIAL2;
    assign mult_op     = is_special && instr.funct inside {FN_MULT, FN_MULTU};
    assign div_op      = is_special && instr.funct inside {FN_DIV, FN_DIVU};
    assign madd_op     = is_special2 && instr.funct inside {FN2_MADD, FN2_MADDU};
    assign msub_op     = is_special2 && instr.funct inside {FN2_MSUB, FN2_MSUBU};
    assign mthi_op     = is_special && instr.funct == FN_MTHI;
    assign mtlo_op     = is_special && instr.funct == FN_MTLO;

    always_comb
    begin
        ctrl.mul_en   = mult_op || madd_op || msub_op || (is_special2 && instr.funct == FN2_MUL);
        ctrl.mul_sign = (is_special && instr.funct == FN_MULT)
                        || (is_special2 && instr.funct inside {FN2_MUL, FN2_MADD, FN2_MSUB});
        ctrl.div_en   = div_op;
        ctrl.div_sign = is_special && instr.funct == FN_DIV;
        ctrl.hi_wen   = mult_op || div_op || madd_op || msub_op || mthi_op;
        ctrl.lo_wen   = mult_op || div_op || madd_op || msub_op || mtlo_op;
        ctrl.mul_mode = MUL_PLAIN;
        if (madd_op)
            ctrl.mul_mode = MUL_ACC;
        else if (msub_op)
            ctrl.mul_mode = MUL_SUB;
        ctrl.hi_sel = HILO_MUL;  // Multiplier result unless divide or move
        ctrl.lo_sel = HILO_MUL;
        if (div_op)
        begin
            ctrl.hi_sel = HILO_DIV;
            ctrl.lo_sel = HILO_DIV;
        end
        if (mthi_op)
            ctrl.hi_sel = HILO_RS;
        if (mtlo_op)
            ctrl.lo_sel = HILO_RS;
    end

endmodule

// File: design/mem_decoder.sv
`timescale 1ns/100ps

module mem_decoder import decode_pkg::*; (
    input  instr_t    instr,
    output mem_ctrl_t ctrl
);

    always_comb
    begin
        ctrl.memreq     = is_load(instr.op) || is_store(instr.op);
        ctrl.memwr      = is_store(instr.op);
        ctrl.memtoreg   = is_load(instr.op);
        ctrl.rdata_sign = instr.op inside {OP_LB, OP_LH, OP_LW};
        ctrl.size       = SIZE_BYTE;
        ctrl.lwlr       = LR_NONE;
        ctrl.swlr       = LR_NONE;
        case (instr.op)
            OP_LH, OP_LHU, OP_SH: ctrl.size = SIZE_HALF;
            OP_LW, OP_SW:         ctrl.size = SIZE_WORD;
            OP_LWL:
            begin
                ctrl.size = SIZE_WORD;  // Unaligned forms are word accesses
                ctrl.lwlr = LR_LEFT;
            end
            OP_LWR:
            begin
                ctrl.size = SIZE_WORD;
                ctrl.lwlr = LR_RIGHT;
            end
            OP_SWL:
            begin
                ctrl.size = SIZE_WORD;
                ctrl.swlr = LR_LEFT;
            end
            OP_SWR:
            begin
                ctrl.size = SIZE_WORD;
                ctrl.swlr = LR_RIGHT;
            end
            default: ;
        endcase
    end

endmodule

// File: design/exec_decoder.sv
`timescale 1ns/100ps

module exec_decoder import decode_pkg::*; (
    input  instr_t     instr,
    output exec_ctrl_t ctrl
);

    always_comb
    begin
        ctrl.alu_func         = ALU_ADD;  // Also address add for loads and stores
        ctrl.sft_func         = SFT_LUI;
        ctrl.alu_srcb_sel_rt  = 1'b0;
        ctrl.sft_srcb_sel_rs  = 1'b0;
        ctrl.sft_srca_sel_imm = instr.op == OP_LUI;
        ctrl.imm_sign         = instr.op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU}
                                || is_load(instr.op) || is_store(instr.op);
        ctrl.intovf_en        = instr.op == OP_ADDI;
        case (instr.op)
            OP_SPECIAL:
            begin
                ctrl.alu_srcb_sel_rt = instr.funct inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                    FN_SLT, FN_SLTU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                    FN_MULT, FN_MULTU, FN_DIV, FN_DIVU};
                ctrl.sft_srcb_sel_rs = instr.funct inside {FN_SLLV, FN_SRLV, FN_SRAV};
                ctrl.intovf_en       = instr.funct inside {FN_ADD, FN_SUB};
                case (instr.funct)
                    FN_SUB, FN_SUBU: ctrl.alu_func = ALU_SUB;
                    FN_SLT:          ctrl.alu_func = ALU_SLT;
                    FN_SLTU:         ctrl.alu_func = ALU_SLTU;
                    FN_AND:          ctrl.alu_func = ALU_AND;
                    FN_NOR:          ctrl.alu_func = ALU_NOR;
                    FN_OR:           ctrl.alu_func = ALU_OR;
                    FN_XOR:          ctrl.alu_func = ALU_XOR;
                    FN_SLL, FN_SLLV: ctrl.sft_func = SFT_SLL;
                    FN_SRA, FN_SRAV: ctrl.sft_func = SFT_SRA;
                    FN_SRL, FN_SRLV: ctrl.sft_func = SFT_SRL;
                    default: ;
                endcase
            end
            OP_SPECIAL2:  // Accumulating forms read rt as second operand
                ctrl.alu_srcb_sel_rt = instr.funct inside {FN2_MADD, FN2_MADDU,
                    FN2_MSUB, FN2_MSUBU};
            OP_SLTI:  ctrl.alu_func = ALU_SLT;
            OP_SLTIU: ctrl.alu_func = ALU_SLTU;
            OP_ANDI:  ctrl.alu_func = ALU_AND;
            OP_ORI:   ctrl.alu_func = ALU_OR;
            OP_XORI:  ctrl.alu_func = ALU_XOR;
            default: ;
        endcase
    end

endmodule

// File: design/flow_decoder.sv
`timescale 1ns/100ps

module flow_decoder import decode_pkg::*; (
    input  instr_t     instr,
    output flow_ctrl_t ctrl
);

    always_comb
    begin
        ctrl.isbranch = 1'b0;
        ctrl.isjump   = 1'b0;
        ctrl.branch   = BR_BEQ;
        ctrl.jump     = JMP_J;
        ctrl.link     = 1'b0;
        case (instr.op)
            OP_BEQ:  ctrl.isbranch = 1'b1;
            OP_BNE:
            begin
                ctrl.isbranch = 1'b1;
                ctrl.branch   = BR_BNE;
            end
            OP_BLEZ:
            begin
                ctrl.isbranch = 1'b1;
                ctrl.branch   = BR_BLEZ;
            end
            OP_BGTZ:
            begin
                ctrl.isbranch = 1'b1;
                ctrl.branch   = BR_BGTZ;
            end
            OP_REGIMM:
            begin
                ctrl.isbranch = 1'b1;  // Unknown rt still counts, flagged reserved elsewhere
                ctrl.link     = instr.rt inside {RI_BLTZAL, RI_BGEZAL};
                case (instr.rt)
                    RI_BLTZ:   ctrl.branch = BR_BLTZ;
                    RI_BGEZ:   ctrl.branch = BR_BGEZ;
                    RI_BLTZAL: ctrl.branch = BR_BLTZAL;
                    RI_BGEZAL: ctrl.branch = BR_BGEZAL;
                    default: ;
                endcase
            end
            OP_J:    ctrl.isjump = 1'b1;
            OP_JAL:
            begin
                ctrl.isjump = 1'b1;
                ctrl.jump   = JMP_JAL;
                ctrl.link   = 1'b1;
            end
            OP_SPECIAL:
            begin
                ctrl.isjump = instr.funct inside {FN_JR, FN_JALR};
                ctrl.link   = instr.funct == FN_JALR;
                if (instr.funct == FN_JR)
                    ctrl.jump = JMP_JR;
                else if (instr.funct == FN_JALR)
                    ctrl.jump = JMP_JALR;
            end
            default: ;
        endcase
    end

endmodule

// File: design/main_decoder.sv
`timescale 1ns/100ps

module main_decoder import decode_pkg::*; (
    input  instr_t     instr,
    output main_ctrl_t ctrl
);

    always_comb
    begin
        ctrl.out_sel  = OUT_ALU;
        ctrl.regwrite = 1'b0;
        ctrl.regdst   = DST_RT;
        ctrl.reserved = 1'b0;
        ctrl.brk      = 1'b0;
        ctrl.syscall  = 1'b0;
        case (instr.op)
            OP_SPECIAL:
            begin
                case (instr.funct)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                    FN_AND, FN_OR, FN_XOR, FN_NOR, FN_JALR:
                        ctrl.regwrite = 1'b1;
                    FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV:
                    begin
                        ctrl.out_sel  = OUT_SHIFT;
                        ctrl.regwrite = 1'b1;
                    end
                    FN_MFHI:
                    begin
                        ctrl.out_sel  = OUT_HI;
                        ctrl.regwrite = 1'b1;
                    end
                    FN_MFLO:
                    begin
                        ctrl.out_sel  = OUT_LO;
                        ctrl.regwrite = 1'b1;
                    end
                    FN_BREAK:   ctrl.brk = 1'b1;
                    FN_SYSCALL: ctrl.syscall = 1'b1;
                    FN_JR, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MTHI, FN_MTLO,
                    FN_SYNC: ;  // No GPR write, SYNC is a no-op
                    default:    ctrl.reserved = 1'b1;
                endcase
            end
            OP_SPECIAL2:
            begin
                case (instr.funct)
                    FN2_MUL:
                    begin
                        ctrl.out_sel  = OUT_MUL;
                        ctrl.regwrite = 1'b1;
                    end
                    FN2_MADD, FN2_MADDU, FN2_MSUB, FN2_MSUBU: ;  // HI/LO only
                    default: ctrl.reserved = 1'b1;
                endcase
            end
            OP_REGIMM:
            begin
                // Anything but plain BLTZ/BGEZ writes r31, even unknown codes
                if (!(instr.rt inside {RI_BLTZ, RI_BGEZ}))
                begin
                    ctrl.regwrite = 1'b1;
                    ctrl.regdst   = DST_R31;
                end
                ctrl.reserved = !(instr.rt inside {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL});
            end
            OP_JAL:
            begin
                ctrl.regwrite = 1'b1;
                ctrl.regdst   = DST_R31;
            end
            OP_J, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: ;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI:
                ctrl.regwrite = 1'b1;
            OP_LUI:
            begin
                ctrl.out_sel  = OUT_SHIFT;
                ctrl.regwrite = 1'b1;
            end
            default:
            begin
                ctrl.regwrite = is_load(instr.op);
                ctrl.reserved = !is_load(instr.op) && !is_store(instr.op);
            end
        endcase
        if (instr.op inside {OP_SPECIAL, OP_SPECIAL2} && ctrl.regwrite)
            ctrl.regdst = DST_RD;  // R-format result goes to rd
    end

endmodule

// File: design/decode_pkg.sv
package decode_pkg;

    localparam int INSTR_W = 32;
    localparam int OP_W    = 6;
    localparam int FUNCT_W = 6;
    localparam int REG_W   = 5;
    localparam int SHAMT_W = INSTR_W - OP_W - 3 * REG_W - FUNCT_W;  // R-format leftover, 5

    typedef enum logic [OP_W-1:0] {
        OP_SPECIAL  = 6'b000000, OP_REGIMM = 6'b000001, OP_J     = 6'b000010,
        OP_JAL      = 6'b000011, OP_BEQ    = 6'b000100, OP_BNE   = 6'b000101,
        OP_BLEZ     = 6'b000110, OP_BGTZ   = 6'b000111, OP_ADDI  = 6'b001000,
        OP_ADDIU    = 6'b001001, OP_SLTI   = 6'b001010, OP_SLTIU = 6'b001011,
        OP_ANDI     = 6'b001100, OP_ORI    = 6'b001101, OP_XORI  = 6'b001110,
        OP_LUI      = 6'b001111, OP_SPECIAL2 = 6'b011100,
        OP_LB       = 6'b100000, OP_LH     = 6'b100001, OP_LWL   = 6'b100010,
        OP_LW       = 6'b100011, OP_LBU    = 6'b100100, OP_LHU   = 6'b100101,
        OP_LWR      = 6'b100110, OP_SB     = 6'b101000, OP_SH    = 6'b101001,
        OP_SWL      = 6'b101010, OP_SW     = 6'b101011, OP_SWR   = 6'b101110
    } opcode_e;

    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL     = 6'b000000, FN_SRL   = 6'b000010, FN_SRA   = 6'b000011,
        FN_SLLV    = 6'b000100, FN_SRLV  = 6'b000110, FN_SRAV  = 6'b000111,
        FN_JR      = 6'b001000, FN_JALR  = 6'b001001, FN_SYSCALL = 6'b001100,
        FN_BREAK   = 6'b001101, FN_SYNC  = 6'b001111, FN_MFHI  = 6'b010000,
        FN_MTHI    = 6'b010001, FN_MFLO  = 6'b010010, FN_MTLO  = 6'b010011,
        FN_MULT    = 6'b011000, FN_MULTU = 6'b011001, FN_DIV   = 6'b011010,
        FN_DIVU    = 6'b011011, FN_ADD   = 6'b100000, FN_ADDU  = 6'b100001,
        FN_SUB     = 6'b100010, FN_SUBU  = 6'b100011, FN_AND   = 6'b100100,
        FN_OR      = 6'b100101, FN_XOR   = 6'b100110, FN_NOR   = 6'b100111,
        FN_SLT     = 6'b101010, FN_SLTU  = 6'b101011
    } funct_e;

    // SPECIAL2 codes overlap the SPECIAL ones
    localparam logic [FUNCT_W-1:0] FN2_MADD  = 6'b000000;
    localparam logic [FUNCT_W-1:0] FN2_MADDU = 6'b000001;
    localparam logic [FUNCT_W-1:0] FN2_MUL   = 6'b000010;
    localparam logic [FUNCT_W-1:0] FN2_MSUB  = 6'b000100;
    localparam logic [FUNCT_W-1:0] FN2_MSUBU = 6'b000101;

    typedef enum logic [REG_W-1:0] {
        RI_BLTZ = 5'b00000, RI_BGEZ = 5'b00001, RI_BLTZAL = 5'b10000, RI_BGEZAL = 5'b10001
    } regimm_e;

    typedef struct packed {
        opcode_e            op;
        logic [REG_W-1:0]   rs;
        logic [REG_W-1:0]   rt;
        logic [REG_W-1:0]   rd;
        logic [SHAMT_W-1:0] shamt;
        logic [FUNCT_W-1:0] funct;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR, ALU_OR, ALU_XOR
    } alu_func_e;
    typedef enum logic [1:0] {SFT_LUI, SFT_SLL, SFT_SRA, SFT_SRL} sft_func_e;
    typedef enum logic [2:0] {
        BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_BGEZAL, BR_BLTZAL
    } branch_e;
    typedef enum logic [1:0] {JMP_J, JMP_JR, JMP_JAL, JMP_JALR} jump_e;
    typedef enum logic [2:0] {OUT_ALU, OUT_SHIFT, OUT_HI, OUT_LO, OUT_MUL} out_sel_e;
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_R31} regdst_e;
    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;
    typedef enum logic [1:0] {LR_NONE, LR_LEFT, LR_RIGHT} lr_e;
    typedef enum logic [1:0] {HILO_MUL, HILO_DIV, HILO_RS} hilo_sel_e;
    typedef enum logic [1:0] {MUL_PLAIN, MUL_ACC, MUL_SUB} mul_mode_e;

    typedef struct packed {
        out_sel_e out_sel;
        logic     regwrite;
        regdst_e  regdst;
        logic     reserved;
        logic     brk;
        logic     syscall;
    } main_ctrl_t;

    typedef struct packed {
        logic    isbranch;
        logic    isjump;
        branch_e branch;
        jump_e   jump;
        logic    link;
    } flow_ctrl_t;

    typedef struct packed {
        alu_func_e alu_func;
        sft_func_e sft_func;
        logic      alu_srcb_sel_rt;
        logic      sft_srcb_sel_rs;
        logic      sft_srca_sel_imm;
        logic      imm_sign;
        logic      intovf_en;
    } exec_ctrl_t;

    typedef struct packed {
        logic      memreq;
        logic      memwr;
        mem_size_e size;
        logic      rdata_sign;
        logic      memtoreg;
        lr_e       lwlr;
        lr_e       swlr;
    } mem_ctrl_t;

    typedef struct packed {
        logic      mul_en;
        logic      mul_sign;
        mul_mode_e mul_mode;
        logic      div_en;
        logic      div_sign;
        hilo_sel_e hi_sel;
        hilo_sel_e lo_sel;
        logic      hi_wen;
        logic      lo_wen;
    } muldiv_ctrl_t;

    typedef struct packed {
        main_ctrl_t   main;
        flow_ctrl_t   flow;
        exec_ctrl_t   exec;
        mem_ctrl_t    mem;
        muldiv_ctrl_t muldiv;
    } ctrl_t;

    typedef struct packed {
        instr_t instr;
        ctrl_t  ctrl;
    } decoded_t;

    function automatic logic is_load(opcode_e op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
    endfunction

    function automatic logic is_store(opcode_e op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
    endfunction

endpackage
